/* all.f */
+incdir+src
src/img_pkg.sv
src/reg_pkg.sv
src/line_buffer.sv
src/window_datapath.sv
src/window_sum.sv
src/ctrl_regs.sv
src/filter_top.sv
sim/filter_asserts.sv
sim/filter_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = filter_tb
FLIST     = all.f
OBJ_DIR   = obj_dir
RUN_ARGS  = +verilator+error+limit+1000
PASS_MSG  = Done: no errors

.PHONY: sim clean

# The run passes only if the pass message shows up in the simulator output.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | awk '{ print } /$(PASS_MSG)/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

/* sim/filter_tb.sv */
`timescale 1ns/100ps
`include "win_config.svh"

module filter_tb
  import img_pkg::*;
  import reg_pkg::*;
();

  localparam int FRAME_PIX   = `IMG_COLS * `IMG_ROWS;
  localparam int FRAME_SUMS  = (`IMG_COLS - `WIN + 1) * (`IMG_ROWS - `WIN + 1);
  localparam int NUM_FRAMES  = 5;
  localparam int CYCLE_LIMIT = 2 * NUM_FRAMES * FRAME_PIX + 2000;  // Gaps stay well under 2x.

  logic        clk;
  logic        rst_n;
  pix_t        pix_i;
  logic        pix_valid_i;
  sum_t        sum_o;
  logic        sum_valid_o;
  logic [31:0] awaddr_i;
  logic        awvalid_i;
  logic        awready_o;
  logic [31:0] wdata_i;
  logic        wvalid_i;
  logic        wready_o;
  logic [1:0]  bresp_o;
  logic        bvalid_o;
  logic        bready_i;
  logic [31:0] araddr_i;
  logic        arvalid_i;
  logic        arready_o;
  logic [31:0] rdata_o;
  logic [1:0]  rresp_o;
  logic        rvalid_o;
  logic        rready_i;

  pix_t        img [`IMG_ROWS][`IMG_COLS];  // Copy of the frame being streamed.
  sum_t        exp_q [$];
  sum_t        last_exp;
  sum_t        exp_sum;
  logic [31:0] lcg_state;
  int          err_cnt   = 0;
  int          sums_seen = 0;
  int          cycle_cnt = 0;
  int          test_num  = 0;
  int          err_mark;
  int          sum_mark;
  int          total_err;

  filter_top filter_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Done: errors found");
      $finish;
    end
  end

  // --------------------
  // Model and checker
  // --------------------
  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  function automatic sum_t window_ref(input int row, input int col);
    int acc;
    acc = 0;
    for (int r = row - `WIN + 1; r <= row; r++) begin
      for (int c = col - `WIN + 1; c <= col; c++) begin
        acc += int'(img[r][c]);
      end
    end
    return sum_t'(acc);
  endfunction

  // Outputs are settled by the falling edge.
  always @(negedge clk) begin
    if (rst_n && sum_valid_o) begin
      sums_seen++;
      assert (exp_q.size() > 0) else begin
        err_cnt++;
        $display("Unexpected sum %0d at %0t with no window pending", sum_o, $time);
      end
      if (exp_q.size() > 0) begin
        exp_sum = exp_q.pop_front();
        assert (sum_o == exp_sum) else begin
          err_cnt++;
          $display("ERR %0t: sum %0d, expected %0d", $time, sum_o, exp_sum);
        end
      end
    end
  end

  // --------------------
  // Bus and stream tasks
  // --------------------
  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
    awaddr_i  = addr;
    wdata_i   = data;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    step(1);
    while (!awready_o) step(1);
    step(1);                      // Handshake edge.
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    while (!bvalid_o) step(1);
    assert (bresp_o == 2'b00) else begin
      err_cnt++;
      $display("ERR %0t: bresp 0x%0h, expected OKAY", $time, bresp_o);
    end
    step(1);                      // Response waits a cycle on bready.
    bready_i = 1'b1;
    step(1);
    bready_i = 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
    araddr_i  = addr;
    arvalid_i = 1'b1;
    step(1);
    while (!arready_o) step(1);
    step(1);
    arvalid_i = 1'b0;
    while (!rvalid_o) step(1);
    data = rdata_o;
    assert (rresp_o == 2'b00) else begin
      err_cnt++;
      $display("ERR %0t: rresp 0x%0h, expected OKAY", $time, rresp_o);
    end
    step(1);
    rready_i = 1'b1;
    step(1);
    rready_i = 1'b0;
  endtask

  task automatic check_reg(input string what, input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    axi_read(addr, got);
    assert (got == exp) else begin
      err_cnt++;
      $display("ERR %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  // Streams pixels in raster order from row 0 and queues every full window.
  task automatic stream_pixels(input int n_pix, input bit gaps);
    int r;
    int c;
    for (int i = 0; i < n_pix; i++) begin
      r = i / `IMG_COLS;
      c = i % `IMG_COLS;
      while (gaps && (lcg_next() % 16'd4 == 16'd0)) step(1);
      img[r][c]   = pix_t'(lcg_next());
      pix_i       = img[r][c];
      pix_valid_i = 1'b1;
      if (r >= `WIN - 1 && c >= `WIN - 1) begin
        last_exp = window_ref(r, c);
        exp_q.push_back(last_exp);
      end
      step(1);
      pix_valid_i = 1'b0;
    end
  endtask

  task automatic stream_ignored(input int n_pix);
    for (int i = 0; i < n_pix; i++) begin
      pix_i       = pix_t'(lcg_next());
      pix_valid_i = 1'b1;
      step(1);
    end
    pix_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() > 0) step(1);
    step(4);  // COUNT and LAST update after the last sum.
  endtask

  task automatic begin_test();
    test_num++;
    err_mark = err_cnt;
    sum_mark = sums_seen;
  endtask

  task automatic end_test(input string name);
    $display("Test %0d, %s: %0d errors", test_num, name, err_cnt - err_mark);
  endtask

  task automatic check_sum_count(input int n);
    assert (sums_seen - sum_mark == n) else begin
      err_cnt++;
      $display("ERR %0t: %0d sums seen, expected %0d", $time, sums_seen - sum_mark, n);
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    pix_i       = '0;
    pix_valid_i = 1'b0;
    awaddr_i    = '0;
    awvalid_i   = 1'b0;
    wdata_i     = '0;
    wvalid_i    = 1'b0;
    bready_i    = 1'b0;
    araddr_i    = '0;
    arvalid_i   = 1'b0;
    rready_i    = 1'b0;
    lcg_state   = 32'd61040;
    rst_n       = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    step(1);

    begin_test();
    assert (!sum_valid_o && !bvalid_o && !rvalid_o) else begin
      err_cnt++;
      $display("ERR %0t: outputs were not idle after reset", $time);
    end
    check_reg("CTRL", ADDR_CTRL, 32'h0);
    end_test("reset state");

    begin_test();
    axi_write(ADDR_CTRL, 32'hA5C3_5A3C);  // Enable and clear bits both zero.
    check_reg("CTRL", ADDR_CTRL, 32'hA5C3_5A3C);
    axi_write(ADDR_STATUS, 32'hFFFF_FFFF);
    check_reg("STATUS", ADDR_STATUS, 32'h0);
    check_reg("CTRL", ADDR_CTRL, 32'hA5C3_5A3C);
    axi_write(ADDR_CTRL, 32'h0);
    end_test("register access");

    begin_test();
    axi_write(ADDR_CTRL, 32'h1);
    stream_pixels(FRAME_PIX, 1'b0);
    wait_drain();
    check_sum_count(FRAME_SUMS);
    check_reg("COUNT", ADDR_COUNT, 32'(FRAME_SUMS));
    check_reg("LAST", ADDR_LAST, 32'(last_exp));
    check_reg("STATUS", ADDR_STATUS, 32'h1);
    check_reg("STATUS", ADDR_STATUS, 32'h0);  // Cleared by the read before.
    end_test("full frame");

    begin_test();
    stream_pixels(FRAME_PIX, 1'b1);
    wait_drain();
    check_sum_count(FRAME_SUMS);
    check_reg("COUNT", ADDR_COUNT, 32'(2 * FRAME_SUMS));
    check_reg("LAST", ADDR_LAST, 32'(last_exp));
    end_test("frame with gaps");

    begin_test();
    axi_write(ADDR_CTRL, 32'h0);
    stream_ignored(`WIN * `IMG_COLS);  // Reaches rows that would give windows.
    axi_write(ADDR_CTRL, 32'h1);
    step(8);
    check_sum_count(0);
    check_reg("COUNT", ADDR_COUNT, 32'(2 * FRAME_SUMS));
    stream_pixels(FRAME_PIX, 1'b0);  // Lines up only if the frame did not advance.
    wait_drain();
    check_sum_count(FRAME_SUMS);
    end_test("disabled input");

    begin_test();
    stream_pixels(`WIN * `IMG_COLS + 5, 1'b0);
    wait_drain();
    check_reg("COUNT", ADDR_COUNT, 32'(3 * FRAME_SUMS + `IMG_COLS - `WIN + 1));
    axi_write(ADDR_CTRL, 32'h3);
    check_reg("COUNT", ADDR_COUNT, 32'h0);
    sum_mark = sums_seen;
    stream_pixels(FRAME_PIX, 1'b0);
    wait_drain();
    check_sum_count(FRAME_SUMS);
    check_reg("COUNT", ADDR_COUNT, 32'(FRAME_SUMS));
    check_reg("LAST", ADDR_LAST, 32'(last_exp));
    end_test("clear mid-frame");

    assert (exp_q.size() == 0) else begin
      err_cnt++;
      $display("Windows still pending at the end of the run");
    end
    total_err = err_cnt + filter_top_inst.filter_asserts_inst.fail_cnt;
    $display("Tests run: %0d, sums checked: %0d, errors: %0d", test_num, sums_seen, total_err);
    if (total_err == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* sim/filter_asserts.sv */
`timescale 1ns/100ps

module filter_asserts
  import reg_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input logic [31:0] awaddr_i,
  input logic        awvalid_i,
  input logic        awready_i,
  input logic [31:0] wdata_i,
  input logic        wvalid_i,
  input logic        wready_i,
  input logic        bvalid_i,
  input logic        bready_i,
  input logic        rvalid_i,
  input logic        rready_i,
  input logic [31:0] rdata_i,
  input logic        sum_valid_i
);

  int   fail_cnt = 0;  // Read by the testbench at the end of the run.
  logic en_seen;       // Follows the enable bit of CTRL.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      en_seen <= 1'b0;
    end else if (awvalid_i && awready_i && wvalid_i && wready_i && (awaddr_i == ADDR_CTRL)) begin
      en_seen <= wdata_i[0];
    end
  end

  // --------------------
  // AXI4-Lite handshakes
  // --------------------
  bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid_i && !bready_i |=> bvalid_i)
    else begin fail_cnt++; $error("bvalid dropped before bready"); end

  rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
    else begin fail_cnt++; $error("rvalid or rdata changed before rready"); end

  ready_needs_valids: assert property (@(posedge clk) disable iff (!rst_n)
    awready_i |-> wready_i && awvalid_i && wvalid_i)
    else begin fail_cnt++; $error("awready without both write valids"); end

  // No sum can come out before a pixel taken after enable has crossed the pipeline.
  no_early_sum: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(en_seen) |-> !sum_valid_i ##1 !sum_valid_i ##1 !sum_valid_i ##1 !sum_valid_i)
    else begin fail_cnt++; $error("sum_valid_o rose too soon after enable"); end

endmodule

bind filter_top filter_asserts filter_asserts_inst (
  .clk         (clk),
  .rst_n       (rst_n),
  .awaddr_i    (awaddr_i),
  .awvalid_i   (awvalid_i),
  .awready_i   (awready_o),
  .wdata_i     (wdata_i),
  .wvalid_i    (wvalid_i),
  .wready_i    (wready_o),
  .bvalid_i    (bvalid_o),
  .bready_i    (bready_i),
  .rvalid_i    (rvalid_o),
  .rready_i    (rready_i),
  .rdata_i     (rdata_o),
  .sum_valid_i (sum_valid_o)
);

/* src/filter_top.sv */
`timescale 1ns/100ps
`include "win_config.svh"

module filter_top
  import img_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  pix_t        pix_i,
  input  logic        pix_valid_i,
  output sum_t        sum_o,
  output logic        sum_valid_o,
  input  logic [31:0] awaddr_i,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [31:0] wdata_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  output logic [1:0]  bresp_o,
  output logic        bvalid_o,
  input  logic        bready_i,
  input  logic [31:0] araddr_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  output logic [31:0] rdata_o,
  output logic [1:0]  rresp_o,
  output logic        rvalid_o,
  input  logic        rready_i
);

  logic            pix_en;
  logic            clr;
  col_t            col_data;
  logic            col_valid;
  col_t [`WIN-1:0] win;
  logic            win_valid;
  logic            frame_end;

  ctrl_regs ctrl_regs_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .awaddr_i    (awaddr_i),
    .awvalid_i   (awvalid_i),
    .awready_o   (awready_o),
    .wdata_i     (wdata_i),
    .wvalid_i    (wvalid_i),
    .wready_o    (wready_o),
    .bresp_o     (bresp_o),
    .bvalid_o    (bvalid_o),
    .bready_i    (bready_i),
    .araddr_i    (araddr_i),
    .arvalid_i   (arvalid_i),
    .arready_o   (arready_o),
    .rdata_o     (rdata_o),
    .rresp_o     (rresp_o),
    .rvalid_o    (rvalid_o),
    .rready_i    (rready_i),
    .pix_valid_i (pix_valid_i),
    .pix_en_o    (pix_en),
    .clr_o       (clr),
    .frame_end_i (frame_end),
    .sum_i       (sum_o),
    .sum_valid_i (sum_valid_o)
  );

  // --------------------
  // Pixel pipeline
  // --------------------
  line_buffer line_buffer_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .pix_i       (pix_i),
    .pix_valid_i (pix_en),
    .col_o       (col_data),
    .col_valid_o (col_valid)
  );

  window_datapath window_datapath_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .clr_i       (clr),
    .col_i       (col_data),
    .col_valid_i (col_valid),
    .win_o       (win),
    .win_valid_o (win_valid),
    .frame_end_o (frame_end)
  );

  window_sum window_sum_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .win_i       (win),
    .win_valid_i (win_valid),
    .sum_o       (sum_o),
    .sum_valid_o (sum_valid_o)
  );

endmodule

/* src/ctrl_regs.sv */
`timescale 1ns/100ps

module ctrl_regs
  import img_pkg::*;
  import reg_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] awaddr_i,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [31:0] wdata_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  output logic [1:0]  bresp_o,
  output logic        bvalid_o,
  input  logic        bready_i,
  input  logic [31:0] araddr_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  output logic [31:0] rdata_o,
  output logic [1:0]  rresp_o,
  output logic        rvalid_o,
  input  logic        rready_i,
  input  logic        pix_valid_i,
  output logic        pix_en_o,
  output logic        clr_o,
  input  logic        frame_end_i,
  input  sum_t        sum_i,
  input  logic        sum_valid_i
);

  ctrl_word_u  ctrl;
  ctrl_word_u  wr_word;
  logic        frame_done;
  logic [31:0] out_count;
  sum_t        last_sum;
  logic        aw_go;
  logic        wr_en;
  logic        rd_en;
  logic [31:0] rd_mux;

  assign wr_word.raw = wdata_i;
  assign aw_go       = awvalid_i && wvalid_i && !awready_o && !bvalid_o;
  assign wr_en       = awready_o && awvalid_i && wready_o && wvalid_i;
  assign rd_en       = arready_o && arvalid_i;

  assign pix_en_o = ctrl.f.enable && pix_valid_i;
  assign bresp_o  = RESP_OKAY;
  assign rresp_o  = RESP_OKAY;

  // --------------------
  // Write channels
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
    end else begin
      awready_o <= aw_go;  // Single-cycle pulse once both valids are up.
      wready_o  <= aw_go;
      if (wr_en) begin
        bvalid_o <= 1'b1;
      end else if (bready_i) begin
        bvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ctrl.raw <= '0;
      clr_o    <= 1'b0;
    end else begin
      clr_o <= 1'b0;
      if (wr_en && (awaddr_i == ADDR_CTRL)) begin
        ctrl.raw <= wr_word.raw;
        clr_o    <= wr_word.f.clear;
      end
    end
  end

  // --------------------
  // Status and counters
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      frame_done <= 1'b0;
      out_count  <= '0;
      last_sum   <= '0;
    end else begin
      if (frame_end_i) begin
        frame_done <= 1'b1;
      end else if (rd_en && (araddr_i == ADDR_STATUS)) begin
        frame_done <= 1'b0;  // Clear on read.
      end
      if (clr_o) begin
        out_count <= '0;
      end else if (sum_valid_i) begin
        out_count <= out_count + 1'b1;
      end
      if (sum_valid_i) begin
        last_sum <= sum_i;
      end
    end
  end

  // --------------------
  // Read channels
  // --------------------
  always_comb begin
    case (araddr_i)
      ADDR_CTRL:   rd_mux = ctrl.raw;
      ADDR_STATUS: rd_mux = {31'b0, frame_done};
      ADDR_COUNT:  rd_mux = out_count;
      ADDR_LAST:   rd_mux = 32'(last_sum);
      default:     rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
    end else begin
      arready_o <= arvalid_i && !arready_o && !rvalid_o;
      if (rd_en) begin
        rvalid_o <= 1'b1;
      end else if (rready_i) begin
        rvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata_o <= rd_mux;
    end
  end

endmodule

/* src/window_sum.sv */
`timescale 1ns/100ps
`include "win_config.svh"

module window_sum
  import img_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  col_t [`WIN-1:0] win_i,
  input  logic            win_valid_i,
  output sum_t            sum_o,
  output logic            sum_valid_o
);

  sum_t row_next [`WIN];
  sum_t row_sum  [`WIN];
  sum_t total_next;
  logic row_valid;

  // --------------------
  // Stage one
  // --------------------
  // One sum per window row, across all columns.
  always_comb begin
    for (int r = 0; r < `WIN; r++) begin
      row_next[r] = '0;
      for (int c = 0; c < `WIN; c++) begin
        row_next[r] = row_next[r] + sum_t'(win_i[c][r]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (win_valid_i) begin
      row_sum <= row_next;
    end
  end

  // --------------------
  // Stage two
  // --------------------
  always_comb begin
    total_next = '0;
    for (int r = 0; r < `WIN; r++) begin
      total_next = total_next + row_sum[r];
    end
  end

  always_ff @(posedge clk) begin
    if (row_valid) begin
      sum_o <= total_next;
    end
  end

  // Valid travels with the data.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_valid   <= 1'b0;
      sum_valid_o <= 1'b0;
    end else begin
      row_valid   <= win_valid_i;
      sum_valid_o <= row_valid;
    end
  end

endmodule

/* src/window_datapath.sv */
`timescale 1ns/100ps
`include "win_config.svh"

module window_datapath
  import img_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             clr_i,
  input  col_t             col_i,
  input  logic             col_valid_i,
  output col_t [`WIN-1:0]  win_o,
  output logic             win_valid_o,
  output logic             frame_end_o
);

  cnt_t col_cnt;  // Position of the column now at col_i.
  cnt_t row_cnt;
  logic col_last;
  logic row_last;
  logic in_region;

  assign col_last  = (col_cnt == cnt_t'(`IMG_COLS - 1));
  assign row_last  = (row_cnt == cnt_t'(`IMG_ROWS - 1));

  // Whole window lies inside the image.
  assign in_region = (col_cnt >= cnt_t'(`WIN - 1)) && (row_cnt >= cnt_t'(`WIN - 1));

  // --------------------
  // Window shift chains
  // --------------------
  // Index [WIN-1] is the leftmost and oldest column, [0] the newest.
  always_ff @(posedge clk) begin
    if (col_valid_i) begin
      win_o <= {win_o[`WIN-2:0], col_i};
    end
  end

  // --------------------
  // Position counters
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (clr_i) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (col_valid_i) begin
      if (col_last) begin
        col_cnt <= '0;
        if (row_last) begin
          row_cnt <= '0;  // Wrap for the next frame.
        end else begin
          row_cnt <= row_cnt + 1'b1;
        end
      end else begin
        col_cnt <= col_cnt + 1'b1;
      end
    end
  end

  // Flags line up with the window they describe.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_valid_o <= 1'b0;
      frame_end_o <= 1'b0;
    end else begin
      win_valid_o <= col_valid_i && in_region;
      frame_end_o <= col_valid_i && col_last && row_last;
    end
  end

endmodule

/* src/line_buffer.sv */
`timescale 1ns/100ps
`include "win_config.svh"

module line_buffer
  import img_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  pix_t pix_i,
  input  logic pix_valid_i,
  output col_t col_o,
  output logic col_valid_o
);

  localparam int NLINES = `WIN - 1;
  localparam int PTR_W  = $clog2(`IMG_COLS);

  pix_t             line_mem [NLINES][`IMG_COLS];
  logic [PTR_W-1:0] col_ptr;
  col_t             col_next;

  // The new pixel sits at the bottom, each delay line adds one row above it.
  always_comb begin
    col_next[0] = pix_i;
    for (int k = 1; k < `WIN; k++) begin
      col_next[k] = line_mem[k-1][col_ptr];
    end
  end

  // Each line hands its old entry down the chain as it takes a new one.
  always_ff @(posedge clk) begin
    if (pix_valid_i) begin
      for (int k = 0; k < NLINES; k++) begin
        line_mem[k][col_ptr] <= col_next[k];
      end
      col_o <= col_next;
    end
  end

  // --------------------
  // Shared column pointer
  // --------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_ptr     <= '0;
      col_valid_o <= 1'b0;
    end else begin
      col_valid_o <= pix_valid_i;
      if (pix_valid_i) begin
        if (col_ptr == PTR_W'(`IMG_COLS - 1)) begin
          col_ptr <= '0;
        end else begin
          col_ptr <= col_ptr + 1'b1;
        end
      end
    end
  end

endmodule

/* src/reg_pkg.sv */
package reg_pkg;

  // --------------------
  // Register map
  // --------------------
  localparam logic [31:0] ADDR_CTRL   = 32'h0;
  localparam logic [31:0] ADDR_STATUS = 32'h4;
  localparam logic [31:0] ADDR_COUNT  = 32'h8;
  localparam logic [31:0] ADDR_LAST   = 32'hC;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // --------------------
  // Control word
  // --------------------
  typedef struct packed {
    logic [29:0] rsvd;
    logic        clear;   // Write 1 to zero position and output count.
    logic        enable;  // Pixel acceptance.
  } ctrl_fields_t;

  // Stored and read back as a raw word, decoded through the fields.
  typedef union packed {
    logic [31:0]  raw;
    ctrl_fields_t f;
  } ctrl_word_u;

endpackage

/* src/img_pkg.sv */
`include "win_config.svh"

package img_pkg;

  // One grey-scale sample.
  typedef logic [`PIX_W-1:0] pix_t;

  // One window column.
  // Element [WIN-1] is the top row and the oldest, element [0] the newest row.
  typedef pix_t [`WIN-1:0] col_t;

  // Raw window sum, wide enough for 169 full-scale pixels.
  typedef logic [15:0] sum_t;

  // Row and column position.
  typedef logic [9:0] cnt_t;

endpackage

/* src/win_config.svh */
`ifndef WIN_CONFIG_SVH
`define WIN_CONFIG_SVH

// Image geometry, fixed at build time.
`define IMG_COLS 20
`define IMG_ROWS 16

// Square window side.
`define WIN 13

// Grey-scale sample width.
`define PIX_W 8

`endif
